/* hdl/mem_ctrl_macros.svh */
// size definitions for the multi-client SRAM request controller
// clients, banks, line, address, row and request size widths

`ifndef MEM_CTRL_MACROS_SVH
`define MEM_CTRL_MACROS_SVH

// number of requesting clients
`define MC_NUM_CLIENTS 4

// number of SRAM banks, 8 regions of an even and an odd bank
`define MC_NUM_BANKS 16

// bytes per SRAM line
`define MC_LINE_BYTES 32

// byte address width, region in bits 18..16
`define MC_ADDR_W 19

// row index inside a bank, address bits 15..6
`define MC_ROW_W 10

// request size field, 1 to 32 bytes
`define MC_SIZE_W 6

`endif

/* hdl/mem_ctrl_pkg.sv */
// shared types of the SRAM request controller
// address union, bank number, row, line and size types

`include "mem_ctrl_macros.svh"

package mem_ctrl_pkg;

	// bank number {region, bank_sel}
	typedef logic [$clog2(`MC_NUM_BANKS)-1:0] bank_id_t;

	// row inside one bank
	typedef logic [`MC_ROW_W-1:0] row_t;

	// one full SRAM line
	typedef logic [8*`MC_LINE_BYTES-1:0] line_t;

	// request byte count
	typedef logic [`MC_SIZE_W-1:0] size_t;

	// --------------------
	// byte address, seen flat for the +32 sum or split into its fields
	// --------------------
	typedef union packed {
		logic [`MC_ADDR_W-1:0] flat;
		struct packed {
			// selects one of the 8 regions
			logic [`MC_ADDR_W-`MC_ROW_W-7:0] region;
			row_t row;
			// even or odd bank of the region
			logic bank_sel;
			// byte inside the line
			logic [$clog2(`MC_LINE_BYTES)-1:0] offset;
		} fld;
	} mem_addr_u;

endpackage

/* hdl/split_cmd_if.sv */
// interface for one client's decoded command
// first and second bank halves with data, masks and direction

interface split_cmd_if ();

	// read when set, write otherwise
	logic is_read;
	// access crosses the line end
	logic two_req;

	// first half at the start address, second half at start + 32
	mem_ctrl_pkg::bank_id_t bank0;
	mem_ctrl_pkg::bank_id_t bank1;
	mem_ctrl_pkg::row_t row0;
	mem_ctrl_pkg::row_t row1;

	// write data already shifted into line position
	mem_ctrl_pkg::line_t wdata0;
	mem_ctrl_pkg::line_t wdata1;

	// bit masks of the bytes touched in each half
	mem_ctrl_pkg::line_t mask0;
	mem_ctrl_pkg::line_t mask1;
	// partial line write
	logic mask_en;

	modport src (output is_read, two_req, bank0, bank1, row0, row1,
		wdata0, wdata1, mask0, mask1, mask_en);

	modport dst (input is_read, two_req, bank0, bank1, row0, row1,
		wdata0, wdata1, mask0, mask1, mask_en);

endinterface

/* hdl/req_splitter.sv */
// request decoder for one client
// bank and row decode, line-end split, write data shift and masks

`include "mem_ctrl_macros.svh"

module req_splitter (
	input  logic                      rd_req,
	input  mem_ctrl_pkg::mem_addr_u   rd_addr,
	input  mem_ctrl_pkg::size_t       rd_size,
	input  mem_ctrl_pkg::mem_addr_u   wr_addr,
	input  mem_ctrl_pkg::size_t       wr_size,
	input  mem_ctrl_pkg::line_t       wr_data,
	split_cmd_if.src                  cmd
);

	// ones over count bytes, placed from byte first upward
	function automatic mem_ctrl_pkg::line_t span_mask(
		input logic [$clog2(`MC_LINE_BYTES)-1:0] first,
		input mem_ctrl_pkg::size_t count
	);
		mem_ctrl_pkg::line_t ones;
		ones = '1;
		return (ones >> (9'(8 * `MC_LINE_BYTES) - {count, 3'b000})) << {first, 3'b000};
	endfunction

	mem_ctrl_pkg::mem_addr_u start_addr;
	mem_ctrl_pkg::mem_addr_u next_addr;
	mem_ctrl_pkg::size_t size;
	mem_ctrl_pkg::size_t first_bytes;
	mem_ctrl_pkg::size_t second_bytes;
	logic [$clog2(`MC_LINE_BYTES)-1:0] offset;
	logic [`MC_SIZE_W:0] end_byte;
	logic split;

	// --------------------
	// request selection
	// --------------------
	// read wins when both are asserted
	assign start_addr = rd_req ? rd_addr : wr_addr;
	assign size = rd_req ? rd_size : wr_size;
	assign offset = start_addr.fld.offset;

	// second half lives at start + 32, whatever region that lands in
	assign next_addr.flat = start_addr.flat + `MC_ADDR_W'(`MC_LINE_BYTES);

	// split when the last byte falls past the line end
	assign end_byte = {2'b00, offset} + {1'b0, size};
	assign split = end_byte > (`MC_SIZE_W+1)'(`MC_LINE_BYTES);

	// bytes up to the line end go first, the rest second
	assign first_bytes = split ? mem_ctrl_pkg::size_t'(`MC_LINE_BYTES) - {1'b0, offset} : size;
	assign second_bytes = size - first_bytes;

	// --------------------
	// command outputs
	// --------------------
	assign cmd.is_read = rd_req;
	assign cmd.two_req = split;

	// bank is {region, bank_sel}
	assign cmd.bank0 = {start_addr.fld.region, start_addr.fld.bank_sel};
	assign cmd.row0 = start_addr.fld.row;
	assign cmd.bank1 = {next_addr.fld.region, next_addr.fld.bank_sel};
	assign cmd.row1 = next_addr.fld.row;

	// first half moves up to its offset, second half takes what is left
	assign cmd.wdata0 = wr_data << {offset, 3'b000};
	assign cmd.wdata1 = wr_data >> {first_bytes, 3'b000};

	assign cmd.mask0 = span_mask(offset, first_bytes);
	assign cmd.mask1 = span_mask('0, second_bytes);

	// only an aligned full line can skip the mask
	assign cmd.mask_en = !((offset == '0) && (size == `MC_SIZE_W'(`MC_LINE_BYTES)));

endmodule

/* hdl/client_seq.sv */
// per-client request FSM
// grant record, bank request levels and the valid/ack pulse

`include "mem_ctrl_macros.svh"

module client_seq (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      rd_req,
	input  logic                      wr_req,
	split_cmd_if.dst                  cmd,
	input  logic                      gnt_first,
	input  logic                      gnt_second,
	output logic [`MC_NUM_BANKS-1:0]  bank_req,
	output logic                      half_first_got,
	output logic                      half_second_got,
	output logic                      rd_valid,
	output logic                      wr_ack
);

	typedef enum logic [2:0] {IDLE, READ_ONE, READ_TWO, WRITE_ONE, WRITE_TWO} state_t;

	state_t state;
	state_t next_state;
	// bit 0 first half granted, bit 1 second half granted
	logic [1:0] got;
	logic [1:0] got_next;
	logic [1:0] need;
	logic [1:0] missing;
	logic done;
	logic active;

	// halves this request needs, decoded live while idle
	always_comb begin
		case (state)
			READ_ONE, WRITE_ONE: need = 2'b01;
			READ_TWO, WRITE_TWO: need = 2'b11;
			default: need = {cmd.two_req, 1'b1};
		endcase
	end

	// record complete, this is the pulse cycle
	assign done = (state != IDLE) && (got == need);
	assign active = (state == IDLE) ? (rd_req | wr_req) : !done;
	assign missing = active ? (need & ~got) : 2'b00;

	// a grant only counts against a half still being requested
	assign half_first_got = missing[0] & gnt_first;
	assign half_second_got = missing[1] & gnt_second;

	// request levels for the halves still missing
	always_comb begin
		bank_req = '0;
		if (missing[0])
			bank_req[cmd.bank0] = 1'b1;
		if (missing[1])
			bank_req[cmd.bank1] = 1'b1;
	end

	assign rd_valid = done && ((state == READ_ONE) || (state == READ_TWO));
	assign wr_ack = done && ((state == WRITE_ONE) || (state == WRITE_TWO));

	// --------------------
	// state and grant record
	// --------------------
	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (rd_req | wr_req) begin
					if (cmd.is_read)
						next_state = cmd.two_req ? READ_TWO : READ_ONE;
					else
						next_state = cmd.two_req ? WRITE_TWO : WRITE_ONE;
				end
			end
			default: begin
				// back to idle after the pulse, client changes request next cycle
				if (done)
					next_state = IDLE;
			end
		endcase
	end

	assign got_next = done ? 2'b00 : (got | {half_second_got, half_first_got});

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			got <= 2'b00;
		end else begin
			state <= next_state;
			got <= got_next;
		end
	end

endmodule

/* hdl/read_assembler.sv */
// read data assembly for one client
// holds an early half, joins both halves and right-aligns the result

`include "mem_ctrl_macros.svh"

module read_assembler (
	input  logic                      clk,
	input  logic                      rst_n,
	split_cmd_if.dst                  cmd,
	input  mem_ctrl_pkg::mem_addr_u   rd_addr,
	input  mem_ctrl_pkg::line_t       first_rdata,
	input  mem_ctrl_pkg::line_t       second_rdata,
	input  logic                      half_first_got,
	input  logic                      half_second_got,
	input  logic                      rd_valid,
	output mem_ctrl_pkg::line_t       rd_data
);

	// bank data of a granted half is on the bus this cycle
	logic first_arrives;
	logic second_arrives;
	mem_ctrl_pkg::line_t held_first;
	mem_ctrl_pkg::line_t held_second;
	mem_ctrl_pkg::line_t lo_half;
	mem_ctrl_pkg::line_t hi_half;
	logic [16*`MC_LINE_BYTES-1:0] joined;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			first_arrives <= 1'b0;
			second_arrives <= 1'b0;
		end else begin
			first_arrives <= half_first_got & cmd.is_read;
			second_arrives <= half_second_got & cmd.is_read;
		end
	end

	// keep a half that shows up before its partner
	always_ff @(posedge clk) begin
		if (first_arrives && !rd_valid)
			held_first <= first_rdata;
		if (second_arrives && !rd_valid)
			held_second <= second_rdata;
	end

	// --------------------
	// join and align
	// --------------------
	assign lo_half = first_arrives ? first_rdata : held_first;
	assign hi_half = second_arrives ? second_rdata : held_second;

	// masks clear everything outside the requested bytes
	assign joined = {hi_half & cmd.mask1, lo_half & cmd.mask0} >> {rd_addr.fld.offset, 3'b000};

	assign rd_data = rd_valid ? joined[8*`MC_LINE_BYTES-1:0] : '0;

endmodule

/* hdl/bank_mux.sv */
// bank port mux for one SRAM bank
// picks the granted client's row, data, mask and direction

`include "mem_ctrl_macros.svh"

module bank_mux #(
	parameter int bank_num = 0
) (
	input  logic [`MC_NUM_CLIENTS-1:0] bank_gnt,
	split_cmd_if.dst                   cmds [`MC_NUM_CLIENTS],
	output logic                       rd,
	output logic                       wr,
	output mem_ctrl_pkg::row_t         row,
	output mem_ctrl_pkg::line_t        wdata,
	output mem_ctrl_pkg::line_t        mask,
	output logic                       mask_en
);

	// per-client view: which half this bank serves and its fields
	logic [`MC_NUM_CLIENTS-1:0] cl_read;
	logic [`MC_NUM_CLIENTS-1:0] cl_first;
	logic [`MC_NUM_CLIENTS-1:0] cl_mask_en;
	mem_ctrl_pkg::row_t cl_row [`MC_NUM_CLIENTS];
	mem_ctrl_pkg::line_t cl_wdata [`MC_NUM_CLIENTS];
	mem_ctrl_pkg::line_t cl_mask [`MC_NUM_CLIENTS];

	for (genvar c = 0; c < `MC_NUM_CLIENTS; c++) begin : g_cl
		// bank0 and bank1 never match together, bit 5 differs
		assign cl_first[c] = cmds[c].bank0 == mem_ctrl_pkg::bank_id_t'(bank_num);
		assign cl_read[c] = cmds[c].is_read;
		assign cl_mask_en[c] = cmds[c].mask_en;
		assign cl_row[c] = cl_first[c] ? cmds[c].row0 : cmds[c].row1;
		assign cl_wdata[c] = cl_first[c] ? cmds[c].wdata0 : cmds[c].wdata1;
		assign cl_mask[c] = cl_first[c] ? cmds[c].mask0 : cmds[c].mask1;
	end

	// at most one grant per bank, all zero without one
	always_comb begin
		rd = 1'b0;
		wr = 1'b0;
		row = '0;
		wdata = '0;
		mask = '0;
		mask_en = 1'b0;
		for (int c = 0; c < `MC_NUM_CLIENTS; c++) begin
			if (bank_gnt[c]) begin
				rd = cl_read[c];
				wr = !cl_read[c];
				row = cl_row[c];
				wdata = cl_wdata[c];
				mask = cl_mask[c];
				// mask applies to writes only
				mask_en = !cl_read[c] && cl_mask_en[c];
			end
		end
	end

endmodule

/* hdl/mem_ctrl_top.sv */
// top level of the multi-client SRAM request controller
// per-client decode, sequencing and read assembly, per-bank port muxes

`include "mem_ctrl_macros.svh"

module mem_ctrl_top (
	input  logic                                            clk,
	input  logic                                            rst_n,
	input  logic [`MC_NUM_CLIENTS-1:0]                      rd_req,
	input  logic [`MC_NUM_CLIENTS-1:0]                      wr_req,
	input  logic [`MC_NUM_CLIENTS-1:0][`MC_ADDR_W-1:0]      rd_addr,
	input  logic [`MC_NUM_CLIENTS-1:0][`MC_ADDR_W-1:0]      wr_addr,
	input  logic [`MC_NUM_CLIENTS-1:0][`MC_SIZE_W-1:0]      rd_size,
	input  logic [`MC_NUM_CLIENTS-1:0][`MC_SIZE_W-1:0]      wr_size,
	input  logic [`MC_NUM_CLIENTS-1:0][8*`MC_LINE_BYTES-1:0] wr_data,
	input  logic [`MC_NUM_BANKS-1:0][`MC_NUM_CLIENTS-1:0]   gnt,
	input  logic [`MC_NUM_BANKS-1:0][8*`MC_LINE_BYTES-1:0]  bank_rdata,
	output logic [`MC_NUM_BANKS-1:0][`MC_NUM_CLIENTS-1:0]   bank_req,
	output logic [`MC_NUM_BANKS-1:0]                        bank_rd,
	output logic [`MC_NUM_BANKS-1:0]                        bank_wr,
	output logic [`MC_NUM_BANKS-1:0]                        bank_mask_en,
	output logic [`MC_NUM_BANKS-1:0][`MC_ROW_W-1:0]         bank_row,
	output logic [`MC_NUM_BANKS-1:0][8*`MC_LINE_BYTES-1:0]  bank_wdata,
	output logic [`MC_NUM_BANKS-1:0][8*`MC_LINE_BYTES-1:0]  bank_mask,
	output logic [`MC_NUM_CLIENTS-1:0]                      rd_valid,
	output logic [`MC_NUM_CLIENTS-1:0]                      wr_ack,
	output logic [`MC_NUM_CLIENTS-1:0][8*`MC_LINE_BYTES-1:0] rd_data
);

	// one decoded command per client, shared by sequencer, assembler and muxes
	split_cmd_if cmd_if [`MC_NUM_CLIENTS] ();

	logic [`MC_NUM_CLIENTS-1:0] gnt_first;
	logic [`MC_NUM_CLIENTS-1:0] gnt_second;
	logic [`MC_NUM_CLIENTS-1:0] half_first_got;
	logic [`MC_NUM_CLIENTS-1:0] half_second_got;
	logic [`MC_NUM_CLIENTS-1:0][`MC_NUM_BANKS-1:0] client_bank_req;

	// --------------------
	// per client
	// --------------------
	for (genvar c = 0; c < `MC_NUM_CLIENTS; c++) begin : g_client
		// grants routed back by the banks of each half
		assign gnt_first[c] = gnt[cmd_if[c].bank0][c];
		assign gnt_second[c] = gnt[cmd_if[c].bank1][c];

		req_splitter u_split (
			.rd_req(rd_req[c]), .rd_addr(rd_addr[c]), .rd_size(rd_size[c]),
			.wr_addr(wr_addr[c]), .wr_size(wr_size[c]), .wr_data(wr_data[c]),
			.cmd(cmd_if[c])
		);

		client_seq u_seq (
			.clk(clk), .rst_n(rst_n), .rd_req(rd_req[c]), .wr_req(wr_req[c]),
			.cmd(cmd_if[c]), .gnt_first(gnt_first[c]), .gnt_second(gnt_second[c]),
			.bank_req(client_bank_req[c]), .half_first_got(half_first_got[c]),
			.half_second_got(half_second_got[c]), .rd_valid(rd_valid[c]), .wr_ack(wr_ack[c])
		);

		// read data taken from the banks of each half
		read_assembler u_asm (
			.clk(clk), .rst_n(rst_n), .cmd(cmd_if[c]), .rd_addr(rd_addr[c]),
			.first_rdata(bank_rdata[cmd_if[c].bank0]),
			.second_rdata(bank_rdata[cmd_if[c].bank1]),
			.half_first_got(half_first_got[c]), .half_second_got(half_second_got[c]),
			.rd_valid(rd_valid[c]), .rd_data(rd_data[c])
		);
	end

	// --------------------
	// per bank
	// --------------------
	for (genvar b = 0; b < `MC_NUM_BANKS; b++) begin : g_bank
		// requests regrouped from per client to per bank
		for (genvar c = 0; c < `MC_NUM_CLIENTS; c++) begin : g_req
			assign bank_req[b][c] = client_bank_req[c][b];
		end

		bank_mux #(.bank_num(b)) u_mux (
			.bank_gnt(gnt[b]), .cmds(cmd_if), .rd(bank_rd[b]), .wr(bank_wr[b]),
			.row(bank_row[b]), .wdata(bank_wdata[b]), .mask(bank_mask[b]),
			.mask_en(bank_mask_en[b])
		);
	end

endmodule

/* bench/bank_model.sv */
// SRAM bank models and grant arbiter for the controller testbench
// random grant delays from a Galois LFSR, masked writes, registered reads

`include "mem_ctrl_macros.svh"

module bank_model (
	input  logic                                           clk,
	input  logic                                           rst_n,
	input  logic [`MC_NUM_BANKS-1:0][`MC_NUM_CLIENTS-1:0]  bank_req,
	input  logic [`MC_NUM_BANKS-1:0]                       bank_rd,
	input  logic [`MC_NUM_BANKS-1:0]                       bank_wr,
	input  logic [`MC_NUM_BANKS-1:0]                       bank_mask_en,
	input  logic [`MC_NUM_BANKS-1:0][`MC_ROW_W-1:0]        bank_row,
	input  logic [`MC_NUM_BANKS-1:0][8*`MC_LINE_BYTES-1:0] bank_wdata,
	input  logic [`MC_NUM_BANKS-1:0][8*`MC_LINE_BYTES-1:0] bank_mask,
	output logic [`MC_NUM_BANKS-1:0][`MC_NUM_CLIENTS-1:0]  gnt,
	output logic [`MC_NUM_BANKS-1:0][8*`MC_LINE_BYTES-1:0] bank_rdata
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [8*`MC_LINE_BYTES-1:0] mem [`MC_NUM_BANKS][1 << `MC_ROW_W];
	logic [7:0] lfsr;
	// per bank: a client picked, its remaining delay
	logic [`MC_NUM_BANKS-1:0] busy;
	logic [1:0] owner [`MC_NUM_BANKS];
	logic [1:0] wait_cnt [`MC_NUM_BANKS];

	// galois step, taps 0xb8
	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		return s[0] ? ((s >> 1) ^ 8'hb8) : (s >> 1);
	endfunction

	// same initial byte pattern as the reference memory
	function automatic logic [7:0] fill_byte(input logic [18:0] a);
		return (a[7:0] ^ a[15:8] ^ {5'b0, a[18:16]}) + 8'h5a;
	endfunction

	initial begin
		logic [18:0] a;
		for (int b = 0; b < `MC_NUM_BANKS; b++) begin
			for (int r = 0; r < (1 << `MC_ROW_W); r++) begin
				for (int k = 0; k < `MC_LINE_BYTES; k++) begin
					a = {b[3:1], r[9:0], b[0], k[4:0]};
					mem[b][r][8*k +: 8] = fill_byte(a);
				end
			end
		end
	end

	// grant only while the owner still requests
	always_comb begin
		gnt = '0;
		for (int b = 0; b < `MC_NUM_BANKS; b++) begin
			if (busy[b] && wait_cnt[b] == 2'd0 && bank_req[b][owner[b]])
				gnt[b][owner[b]] = 1'b1;
		end
	end

	// --------------------
	// arbiter state
	// --------------------
	always @(posedge clk or negedge rst_n) begin
		logic [7:0] s;
		logic [1:0] delay;
		int pick;
		if (!rst_n) begin
			lfsr <= 8'd53;
			busy <= '0;
			for (int b = 0; b < `MC_NUM_BANKS; b++) begin
				owner[b] <= 2'd0;
				wait_cnt[b] <= 2'd0;
			end
		end else begin
			s = lfsr;
			for (int b = 0; b < `MC_NUM_BANKS; b++) begin
				if (busy[b]) begin
					// a grant cycle ends the ownership
					if (wait_cnt[b] == 2'd0)
						busy[b] <= 1'b0;
					else
						wait_cnt[b] <= wait_cnt[b] - 2'd1;
				end else if (bank_req[b] != '0) begin
					pick = 0;
					for (int c = `MC_NUM_CLIENTS - 1; c >= 0; c--) begin
						if (bank_req[b][c])
							pick = c;
					end
					// one lfsr step per delay bit
					delay[0] = s[0];
					s = lfsr_next(s);
					delay[1] = s[0];
					s = lfsr_next(s);
					owner[b] <= pick[1:0];
					wait_cnt[b] <= delay;
					busy[b] <= 1'b1;
				end
			end
			lfsr <= s;
		end
	end

	// bank arrays, read data one cycle after the read grant
	always @(posedge clk) begin
		logic [8*`MC_LINE_BYTES-1:0] m;
		for (int b = 0; b < `MC_NUM_BANKS; b++) begin
			if (bank_rd[b])
				bank_rdata[b] <= mem[b][bank_row[b]];
			if (bank_wr[b]) begin
				m = bank_mask_en[b] ? bank_mask[b] : '1;
				mem[b][bank_row[b]] <= (mem[b][bank_row[b]] & ~m) | (bank_wdata[b] & m);
			end
		end
	end

endmodule

/* bench/tb_mem_ctrl.sv */
// testbench for the SRAM request controller
// test table, clock and reset, reference byte memory, checks and reporting

`include "mem_ctrl_macros.svh"

module tb_mem_ctrl;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NC = `MC_NUM_CLIENTS;
	localparam int NB = `MC_NUM_BANKS;
	localparam int NUM_TESTS = 14;
	localparam int CYCLE_LIMIT = NUM_TESTS * 12 + 20;

	logic clk;
	logic rst_n;
	logic [NC-1:0] rd_req;
	logic [NC-1:0] wr_req;
	logic [NC-1:0][`MC_ADDR_W-1:0] rd_addr;
	logic [NC-1:0][`MC_ADDR_W-1:0] wr_addr;
	logic [NC-1:0][`MC_SIZE_W-1:0] rd_size;
	logic [NC-1:0][`MC_SIZE_W-1:0] wr_size;
	logic [NC-1:0][255:0] wr_data;
	logic [NB-1:0][NC-1:0] gnt;
	logic [NB-1:0][255:0] bank_rdata;
	logic [NB-1:0][NC-1:0] bank_req;
	logic [NB-1:0] bank_rd;
	logic [NB-1:0] bank_wr;
	logic [NB-1:0] bank_mask_en;
	logic [NB-1:0][`MC_ROW_W-1:0] bank_row;
	logic [NB-1:0][255:0] bank_wdata;
	logic [NB-1:0][255:0] bank_mask;
	logic [NC-1:0] rd_valid;
	logic [NC-1:0] wr_ack;
	logic [NC-1:0][255:0] rd_data;

	// test table, kind 0 write, 1 read, 2 read and write together
	int t_client [NUM_TESTS];
	int t_kind [NUM_TESTS];
	logic [18:0] t_addr [NUM_TESTS];
	logic [5:0] t_size [NUM_TESTS];
	logic [255:0] t_data [NUM_TESTS];
	// expected bank requests at the start, and a partial-line write
	int t_reqs [NUM_TESTS];
	logic t_mask [NUM_TESTS];
	// entry runs at the same time as the next one
	logic t_pair [NUM_TESTS];
	string t_name [NUM_TESTS];
	int n_loaded;

	logic [7:0] ref_mem [0:524287];
	int errors;
	int tests_run;
	int tests_failed;
	int cycles;

	mem_ctrl_top dut0 (
		.clk(clk), .rst_n(rst_n), .rd_req(rd_req), .wr_req(wr_req),
		.rd_addr(rd_addr), .wr_addr(wr_addr), .rd_size(rd_size), .wr_size(wr_size),
		.wr_data(wr_data), .gnt(gnt), .bank_rdata(bank_rdata), .bank_req(bank_req),
		.bank_rd(bank_rd), .bank_wr(bank_wr), .bank_mask_en(bank_mask_en),
		.bank_row(bank_row), .bank_wdata(bank_wdata), .bank_mask(bank_mask),
		.rd_valid(rd_valid), .wr_ack(wr_ack), .rd_data(rd_data)
	);

	bank_model banks (
		.clk(clk), .rst_n(rst_n), .bank_req(bank_req), .bank_rd(bank_rd),
		.bank_wr(bank_wr), .bank_mask_en(bank_mask_en), .bank_row(bank_row),
		.bank_wdata(bank_wdata), .bank_mask(bank_mask), .gnt(gnt), .bank_rdata(bank_rdata)
	);

	always #2 clk = ~clk;

	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("run timed out after %0d cycles", cycles);
			$display("Errors found");
			$finish;
		end
	end

	function automatic logic [7:0] fill_byte(input logic [18:0] a);
		return (a[7:0] ^ a[15:8] ^ {5'b0, a[18:16]}) + 8'h5a;
	endfunction

	// distinct bytes per entry
	function automatic logic [255:0] data_pattern(input int i);
		logic [255:0] d;
		for (int k = 0; k < 32; k++)
			d[8*k +: 8] = 8'(i * 37 + k * 5 + 3);
		return d;
	endfunction

	task automatic add_entry(input int c, input int kind, input logic [18:0] a,
		input logic [5:0] sz, input int reqs, input logic mask, input logic pair,
		input string name);
		t_client[n_loaded] = c;
		t_kind[n_loaded] = kind;
		t_addr[n_loaded] = a;
		t_size[n_loaded] = sz;
		t_data[n_loaded] = data_pattern(n_loaded);
		t_reqs[n_loaded] = reqs;
		t_mask[n_loaded] = mask;
		t_pair[n_loaded] = pair;
		t_name[n_loaded] = name;
		n_loaded++;
	endtask

	task automatic load_table();
		n_loaded = 0;
		add_entry(0, 0, 19'h01040, 6'd32, 1, 1'b0, 1'b0, "wr_full_line");
		add_entry(0, 1, 19'h01040, 6'd32, 1, 1'b0, 1'b0, "rd_full_line");
		add_entry(0, 0, 19'h02089, 6'd5, 1, 1'b1, 1'b0, "wr_partial");
		add_entry(0, 1, 19'h02080, 6'd32, 1, 1'b0, 1'b0, "rd_partial_line");
		add_entry(1, 0, 19'h30118, 6'd20, 2, 1'b1, 1'b0, "wr_split");
		add_entry(1, 1, 19'h30118, 6'd20, 2, 1'b0, 1'b0, "rd_split");
		add_entry(2, 1, 19'h3010c, 6'd32, 2, 1'b0, 1'b0, "rd_split_wide");
		// same bank 0, different rows
		add_entry(1, 0, 19'h05000, 6'd16, 1, 1'b1, 1'b1, "wr_shared_bank");
		add_entry(2, 1, 19'h05440, 6'd32, 1, 1'b0, 1'b0, "rd_shared_bank");
		add_entry(1, 1, 19'h05000, 6'd16, 1, 1'b0, 1'b0, "rd_after_shared");
		add_entry(3, 2, 19'h06020, 6'd32, 1, 1'b0, 1'b0, "rd_before_wr");
		add_entry(3, 1, 19'h06020, 6'd32, 1, 1'b0, 1'b0, "rd_after_wr");
		// second half wraps past the top of the address space
		add_entry(0, 0, 19'h7fff0, 6'd32, 2, 1'b1, 1'b0, "wr_wrap");
		add_entry(0, 1, 19'h7fff0, 6'd32, 2, 1'b0, 1'b0, "rd_wrap");
	endtask

	// reference bytes from the address up, zero above the size
	function automatic logic [255:0] expected_read(input int i);
		logic [255:0] e;
		logic [18:0] a;
		e = '0;
		for (int k = 0; k < int'(t_size[i]); k++) begin
			a = t_addr[i] + 19'(k);
			e[8*k +: 8] = ref_mem[a];
		end
		return e;
	endfunction

	task automatic update_ref(input int i);
		logic [18:0] a;
		for (int k = 0; k < int'(t_size[i]); k++) begin
			a = t_addr[i] + 19'(k);
			ref_mem[a] = t_data[i][8*k +: 8];
		end
	endtask

	// --------------------
	// wait for valid or ack, checking requests and masks on the way
	// --------------------
	task automatic wait_pulse(input int i, input logic want_read, output logic [255:0] got);
		int c;
		int halves;
		int reqs;
		logic first;
		logic finished;
		logic mask_seen;
		c = t_client[i];
		halves = t_reqs[i];
		first = 1'b1;
		finished = 1'b0;
		mask_seen = 1'b0;
		got = '0;
		while (!finished) begin
			@(negedge clk);
			reqs = 0;
			for (int b = 0; b < NB; b++) begin
				reqs += int'(bank_req[b][c]);
				if (gnt[b][c] && bank_wr[b] && bank_mask_en[b])
					mask_seen = 1'b1;
			end
			if (want_read ? wr_ack[c] : rd_valid[c]) begin
				$display("[ERROR] %s: the wrong completion pulse came first", t_name[i]);
				errors++;
			end
			if (first && reqs != halves) begin
				$display("[ERROR] %s: expected %0d, actual %0d", t_name[i], halves, reqs);
				errors++;
			end
			first = 1'b0;
			if (want_read ? rd_valid[c] : wr_ack[c]) begin
				got = rd_data[c];
				finished = 1'b1;
			end else if (reqs == 0) begin
				$display("[ERROR] %s: bank request dropped before its grant", t_name[i]);
				errors++;
			end
		end
		if (!want_read) begin
			if (mask_seen != t_mask[i]) begin
				$display("[ERROR] %s: expected %0b, actual %0b", t_name[i], t_mask[i],
					mask_seen);
				errors++;
			end
		end
	endtask

	task automatic run_entry(input int i);
		int c;
		int errs_before;
		logic [255:0] exp;
		logic [255:0] got;
		c = t_client[i];
		errs_before = errors;
		exp = '0;
		@(posedge clk);
		#0.5;
		if (t_kind[i] != 0) begin
			rd_addr[c] = t_addr[i];
			rd_size[c] = t_size[i];
			rd_req[c] = 1'b1;
			exp = expected_read(i);
		end
		if (t_kind[i] != 1) begin
			wr_addr[c] = t_addr[i];
			wr_size[c] = t_size[i];
			wr_data[c] = t_data[i];
			wr_req[c] = 1'b1;
		end
		if (t_kind[i] != 0) begin
			wait_pulse(i, 1'b1, got);
			if (got !== exp) begin
				$display("[ERROR] %s: expected %h, actual %h", t_name[i], exp, got);
				errors++;
			end
			@(posedge clk);
			#0.5;
			rd_req[c] = 1'b0;
			// valid is a single-cycle pulse
			@(negedge clk);
			if (rd_valid[c]) begin
				$display("[ERROR] %s: rd_valid stayed high for a second cycle", t_name[i]);
				errors++;
			end
		end
		if (t_kind[i] != 1) begin
			wait_pulse(i, 1'b0, got);
			update_ref(i);
			@(posedge clk);
			#0.5;
			wr_req[c] = 1'b0;
			@(negedge clk);
			if (wr_ack[c]) begin
				$display("[ERROR] %s: wr_ack stayed high for a second cycle", t_name[i]);
				errors++;
			end
		end
		tests_run++;
		if (errors == errs_before) begin
			$display("PASS %s", t_name[i]);
		end else begin
			$display("FAIL %s", t_name[i]);
			tests_failed++;
		end
	endtask

	// --------------------
	// main sequence
	// --------------------
	initial begin
		int i;
		clk = 1'b0;
		rst_n = 1'b0;
		rd_req = '0;
		wr_req = '0;
		rd_addr = '0;
		wr_addr = '0;
		rd_size = '0;
		wr_size = '0;
		wr_data = '0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		cycles = 0;
		for (int a = 0; a < 524288; a++)
			ref_mem[a] = fill_byte(19'(a));
		load_table();

		repeat (3) @(posedge clk);
		#0.5;
		rst_n = 1'b1;

		@(negedge clk);
		tests_run++;
		if (rd_valid != '0 || wr_ack != '0 || bank_req != '0 || bank_rd != '0
			|| bank_wr != '0 || bank_mask_en != '0) begin
			$display("[ERROR] reset_state: outputs not all low after reset");
			errors++;
			tests_failed++;
			$display("FAIL reset_state");
		end else begin
			$display("PASS reset_state");
		end

		i = 0;
		while (i < n_loaded) begin
			if (t_pair[i] && i + 1 < n_loaded) begin
				fork
					run_entry(i);
					run_entry(i + 1);
				join
				i += 2;
			end else begin
				run_entry(i);
				i++;
			end
		end

		$display("%0d tests, %0d passed, %0d failed, %0d errors",
			tests_run, tests_run - tests_failed, tests_failed, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

/* build.f */
+incdir+hdl
hdl/mem_ctrl_pkg.sv
hdl/split_cmd_if.sv
hdl/req_splitter.sv
hdl/client_seq.sv
hdl/read_assembler.sv
hdl/bank_mux.sv
hdl/mem_ctrl_top.sv
bench/bank_model.sv
bench/tb_mem_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module tb_mem_ctrl \
	--Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Errors found" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
